// File: common/accel_cfg_pkg.sv
`default_nettype none

package accel_cfg_pkg;

    localparam int AXIL_ADDR_W = 6;
    localparam int DATA_W      = 32;
    localparam int LANES       = 4;
    localparam int ELEM_W      = 8;
    localparam int WBANK_DEPTH = 8;
    localparam int WIDX_W      = 3;
    localparam int OUT_CNT_W   = 8;
    localparam int FIFO_DEPTH  = 4;

    // register map, byte addresses
    localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 6'h00;
    localparam logic [AXIL_ADDR_W-1:0] REG_CONFIG = 6'h04;
    localparam logic [AXIL_ADDR_W-1:0] REG_BIAS   = 6'h08;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 6'h0C;
    localparam logic [AXIL_ADDR_W-1:0] REG_WBASE  = 6'h20;

    typedef logic signed [DATA_W-1:0] acc_t;
    typedef logic [WBANK_DEPTH-1:0][DATA_W-1:0] weight_bank_t;

endpackage

`default_nettype wire

// File: common/accel_ctrl_pkg.sv
`default_nettype none

package accel_ctrl_pkg;

    // layer sequencing
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DRAIN
    } layer_state_t;

    // post-processing after bias add
    typedef enum logic {
        OP_LINEAR,
        OP_RELU
    } op_t;

endpackage

`default_nettype wire

// File: hw/axil_regs.sv
`timescale 1ns/100ps
`default_nettype none

module axil_regs
    import accel_cfg_pkg::*, accel_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [AXIL_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [DATA_W-1:0]      s_axil_wdata_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic [1:0]             s_axil_bresp_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    input  logic [AXIL_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [DATA_W-1:0]      s_axil_rdata_o,
    output logic [1:0]             s_axil_rresp_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i,
    output logic                   start_o,
    output op_t                    op_o,
    output logic [WIDX_W:0]        in_words_o,
    output logic [OUT_CNT_W-1:0]   out_count_o,
    output acc_t                   bias_o,
    output weight_bank_t           weight_bank_o,
    input  logic                   busy_i,
    input  logic                   last_sent_i
);

    logic              wr_en;
    logic              rd_en;
    logic              done;
    logic [DATA_W-1:0] rd_mux;

    assign wr_en = s_axil_awready_o && s_axil_awvalid_i && s_axil_wvalid_i;
    assign rd_en = s_axil_arready_o && s_axil_arvalid_i;

    assign s_axil_bresp_o = 2'b00;
    assign s_axil_rresp_o = 2'b00;

    // write channel, address and data accepted together
    always_ff @(posedge clk) begin
        if (reset_i) begin
            s_axil_awready_o <= 1'b0;
            s_axil_wready_o  <= 1'b0;
            s_axil_bvalid_o  <= 1'b0;
        end else begin
            s_axil_awready_o <= s_axil_awvalid_i && s_axil_wvalid_i &&
                                !s_axil_bvalid_o && !s_axil_awready_o;
            s_axil_wready_o  <= s_axil_awvalid_i && s_axil_wvalid_i &&
                                !s_axil_bvalid_o && !s_axil_awready_o;
            if (wr_en) begin
                s_axil_bvalid_o <= 1'b1;
            end else if (s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            start_o     <= 1'b0;
            op_o        <= OP_LINEAR;
            in_words_o  <= '0;
            out_count_o <= '0;
        end else begin
            start_o <= 1'b0;
            if (wr_en && s_axil_awaddr_i == REG_CTRL) begin
                start_o <= s_axil_wdata_i[0];
                op_o    <= op_t'(s_axil_wdata_i[1]);
            end
            if (wr_en && s_axil_awaddr_i == REG_CONFIG) begin
                in_words_o  <= s_axil_wdata_i[WIDX_W:0];
                out_count_o <= s_axil_wdata_i[8 +: OUT_CNT_W];
            end
        end
    end

    // bias and weight bank
    always_ff @(posedge clk) begin
        if (wr_en && s_axil_awaddr_i == REG_BIAS) begin
            bias_o <= acc_t'(s_axil_wdata_i);
        end
        if (wr_en && s_axil_awaddr_i[AXIL_ADDR_W-1] == REG_WBASE[AXIL_ADDR_W-1]) begin
            weight_bank_o[s_axil_awaddr_i[2 +: WIDX_W]] <= s_axil_wdata_i;
        end
    end

    // sticky done, a new start clears it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            done <= 1'b0;
        end else if (start_o) begin
            done <= 1'b0;
        end else if (last_sent_i) begin
            done <= 1'b1;
        end
    end

    always_comb begin
        rd_mux = '0;
        if (s_axil_araddr_i[AXIL_ADDR_W-1] == REG_WBASE[AXIL_ADDR_W-1]) begin
            rd_mux = weight_bank_o[s_axil_araddr_i[2 +: WIDX_W]];
        end else begin
            case (s_axil_araddr_i)
                REG_CTRL:   rd_mux[1] = op_o;
                REG_CONFIG: begin
                    rd_mux[WIDX_W:0]       = in_words_o;
                    rd_mux[8 +: OUT_CNT_W] = out_count_o;
                end
                REG_BIAS:   rd_mux = bias_o;
                REG_STATUS: begin
                    rd_mux[0] = done;
                    rd_mux[1] = busy_i;
                end
                default:    rd_mux = '0;
            endcase
        end
    end

    // read channel
    always_ff @(posedge clk) begin
        if (reset_i) begin
            s_axil_arready_o <= 1'b0;
            s_axil_rvalid_o  <= 1'b0;
        end else begin
            s_axil_arready_o <= s_axil_arvalid_i && !s_axil_rvalid_o && !s_axil_arready_o;
            if (rd_en) begin
                s_axil_rvalid_o <= 1'b1;
            end else if (s_axil_rready_i) begin
                s_axil_rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            s_axil_rdata_o <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// File: hw/layer_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module layer_ctrl
    import accel_cfg_pkg::*, accel_ctrl_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 start_i,
    input  logic [WIDX_W:0]      in_words_i,
    input  logic [OUT_CNT_W-1:0] out_count_i,
    input  logic                 s_axis_tvalid_i,
    output logic                 s_axis_tready_o,
    input  logic                 fifo_room_i,
    input  logic                 last_sent_i,
    output logic                 beat_valid_o,
    output logic                 first_word_o,
    output logic                 last_word_o,
    output logic                 last_out_o,
    output logic [WIDX_W-1:0]    widx_o,
    output logic                 busy_o
);

    layer_state_t         state;
    logic [WIDX_W-1:0]    word_cnt;
    logic [OUT_CNT_W-1:0] out_cnt;

    // stall input while the output FIFO is short of space
    assign s_axis_tready_o = (state == ST_RUN) && fifo_room_i;
    assign beat_valid_o    = s_axis_tready_o && s_axis_tvalid_i;

    assign first_word_o = (word_cnt == '0);
    assign last_word_o  = ({1'b0, word_cnt} == in_words_i - 1'b1);
    assign last_out_o   = (out_cnt == out_count_i - 1'b1);
    assign widx_o       = word_cnt;
    assign busy_o       = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state    <= ST_IDLE;
            word_cnt <= '0;
            out_cnt  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        state    <= ST_RUN;
                        word_cnt <= '0;
                        out_cnt  <= '0;
                    end
                end
                ST_RUN: begin
                    if (beat_valid_o) begin
                        if (last_word_o) begin
                            word_cnt <= '0;
                            out_cnt  <= out_cnt + 1'b1;
                            // all inputs taken, wait for the final beat out
                            if (last_out_o) begin
                                state <= ST_DRAIN;
                            end
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (last_sent_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: datapath/mac_array.sv
`timescale 1ns/100ps
`default_nettype none

module mac_array
    import accel_cfg_pkg::*, accel_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic [DATA_W-1:0] data_i,
    input  weight_bank_t      weight_bank_i,
    input  logic [WIDX_W-1:0] widx_i,
    input  logic              beat_valid_i,
    input  logic              first_word_i,
    input  logic              last_word_i,
    input  logic              last_out_i,
    input  op_t               op_i,
    input  acc_t              bias_i,
    output logic              res_valid_o,
    output acc_t              res_data_o,
    output logic              res_last_o
);

    logic [DATA_W-1:0] wword;
    acc_t              beat_sum;
    acc_t              acc;
    acc_t              acc_next;
    acc_t              total;
    acc_t              result;

    assign wword = weight_bank_i[widx_i];

    // four signed 8x8 products of the current word
    always_comb begin : lane_products
        logic signed [2*ELEM_W-1:0] prod;
        beat_sum = '0;
        for (int l = 0; l < LANES; l++) begin
            prod = $signed(data_i[l*ELEM_W +: ELEM_W]) *
                   $signed(wword[l*ELEM_W +: ELEM_W]);
            beat_sum = beat_sum + prod;
        end
    end

    // first word of an output starts from zero
    assign acc_next = (first_word_i ? acc_t'(0) : acc) + beat_sum;
    assign total    = acc_next + bias_i;

    always_comb begin
        result = total;
        if (op_i == OP_RELU && total[DATA_W-1]) begin
            result = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            acc <= acc_next;
        end
        if (beat_valid_i && last_word_i) begin
            res_data_o <= result;
            res_last_o <= last_out_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= beat_valid_i && last_word_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/axis_out_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module axis_out_fifo
    import accel_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  wr_valid_i,
    input  logic [DATA_W-1:0]     wr_data_i,
    input  logic                  wr_last_i,
    output logic                  fifo_room_o,
    input  logic                  m_axis_tready_i,
    output logic                  m_axis_tvalid_o,
    output logic [DATA_W-1:0]     m_axis_tdata_o,
    output logic                  m_axis_tlast_o,
    output logic [DATA_W/8-1:0]   m_axis_tstrb_o,
    output logic                  last_sent_o
);

    logic [DATA_W-1:0]             mem_data [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0]         mem_last;
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]   count;
    logic                          rd_en;

    assign m_axis_tvalid_o = (count != '0);
    assign m_axis_tdata_o  = mem_data[rd_ptr];
    assign m_axis_tlast_o  = mem_last[rd_ptr];
    assign m_axis_tstrb_o  = '1;

    assign rd_en       = m_axis_tvalid_o && m_axis_tready_i;
    assign last_sent_o = rd_en && m_axis_tlast_o;

    // two free slots: one for the result in mac_array, one spare
    assign fifo_room_o = (count <= FIFO_DEPTH - 2);

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            mem_data[wr_ptr] <= wr_data_i;
            mem_last[wr_ptr] <= wr_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_valid_i, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/cnn_accel_top.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_accel_top
    import accel_cfg_pkg::*, accel_ctrl_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset_i,
    // AXI-lite slave
    input  logic [AXIL_ADDR_W-1:0] s_axil_awaddr_i,
    input  logic                   s_axil_awvalid_i,
    output logic                   s_axil_awready_o,
    input  logic [DATA_W-1:0]      s_axil_wdata_i,
    input  logic                   s_axil_wvalid_i,
    output logic                   s_axil_wready_o,
    output logic [1:0]             s_axil_bresp_o,
    output logic                   s_axil_bvalid_o,
    input  logic                   s_axil_bready_i,
    input  logic [AXIL_ADDR_W-1:0] s_axil_araddr_i,
    input  logic                   s_axil_arvalid_i,
    output logic                   s_axil_arready_o,
    output logic [DATA_W-1:0]      s_axil_rdata_o,
    output logic [1:0]             s_axil_rresp_o,
    output logic                   s_axil_rvalid_o,
    input  logic                   s_axil_rready_i,
    // input feature map stream, tstrb and tlast not used
    input  logic [DATA_W-1:0]      s_axis_tdata_i,
    input  logic [DATA_W/8-1:0]    s_axis_tstrb_i,
    input  logic                   s_axis_tlast_i,
    input  logic                   s_axis_tvalid_i,
    output logic                   s_axis_tready_o,
    // result stream
    input  logic                   m_axis_tready_i,
    output logic                   m_axis_tvalid_o,
    output logic [DATA_W-1:0]      m_axis_tdata_o,
    output logic                   m_axis_tlast_o,
    output logic [DATA_W/8-1:0]    m_axis_tstrb_o
);

    logic                 start;
    op_t                  op;
    logic [WIDX_W:0]      in_words;
    logic [OUT_CNT_W-1:0] out_count;
    acc_t                 bias;
    weight_bank_t         weight_bank;
    logic                 busy;
    logic                 last_sent;
    logic                 fifo_room;
    logic                 beat_valid;
    logic                 first_word;
    logic                 last_word;
    logic                 last_out;
    logic [WIDX_W-1:0]    widx;
    logic                 res_valid;
    acc_t                 res_data;
    logic                 res_last;

    axil_regs u_axil_regs (
        .clk              (clk),
        .reset_i          (reset_i),
        .s_axil_awaddr_i  (s_axil_awaddr_i),
        .s_axil_awvalid_i (s_axil_awvalid_i),
        .s_axil_awready_o (s_axil_awready_o),
        .s_axil_wdata_i   (s_axil_wdata_i),
        .s_axil_wvalid_i  (s_axil_wvalid_i),
        .s_axil_wready_o  (s_axil_wready_o),
        .s_axil_bresp_o   (s_axil_bresp_o),
        .s_axil_bvalid_o  (s_axil_bvalid_o),
        .s_axil_bready_i  (s_axil_bready_i),
        .s_axil_araddr_i  (s_axil_araddr_i),
        .s_axil_arvalid_i (s_axil_arvalid_i),
        .s_axil_arready_o (s_axil_arready_o),
        .s_axil_rdata_o   (s_axil_rdata_o),
        .s_axil_rresp_o   (s_axil_rresp_o),
        .s_axil_rvalid_o  (s_axil_rvalid_o),
        .s_axil_rready_i  (s_axil_rready_i),
        .start_o          (start),
        .op_o             (op),
        .in_words_o       (in_words),
        .out_count_o      (out_count),
        .bias_o           (bias),
        .weight_bank_o    (weight_bank),
        .busy_i           (busy),
        .last_sent_i      (last_sent)
    );

    layer_ctrl u_layer_ctrl (
        .clk             (clk),
        .reset_i         (reset_i),
        .start_i         (start),
        .in_words_i      (in_words),
        .out_count_i     (out_count),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tready_o (s_axis_tready_o),
        .fifo_room_i     (fifo_room),
        .last_sent_i     (last_sent),
        .beat_valid_o    (beat_valid),
        .first_word_o    (first_word),
        .last_word_o     (last_word),
        .last_out_o      (last_out),
        .widx_o          (widx),
        .busy_o          (busy)
    );

    mac_array u_mac_array (
        .clk           (clk),
        .reset_i       (reset_i),
        .data_i        (s_axis_tdata_i),
        .weight_bank_i (weight_bank),
        .widx_i        (widx),
        .beat_valid_i  (beat_valid),
        .first_word_i  (first_word),
        .last_word_i   (last_word),
        .last_out_i    (last_out),
        .op_i          (op),
        .bias_i        (bias),
        .res_valid_o   (res_valid),
        .res_data_o    (res_data),
        .res_last_o    (res_last)
    );

    axis_out_fifo u_axis_out_fifo (
        .clk             (clk),
        .reset_i         (reset_i),
        .wr_valid_i      (res_valid),
        .wr_data_i       (res_data),
        .wr_last_i       (res_last),
        .fifo_room_o     (fifo_room),
        .m_axis_tready_i (m_axis_tready_i),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tlast_o  (m_axis_tlast_o),
        .m_axis_tstrb_o  (m_axis_tstrb_o),
        .last_sent_o     (last_sent)
    );

endmodule

`default_nettype wire

// File: dv/tb_cnn_accel.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cnn_accel
    import accel_cfg_pkg::*, accel_ctrl_pkg::*;
();

    localparam int TIMEOUT = 500;

    logic                   clk;
    logic                   reset_i;
    logic [AXIL_ADDR_W-1:0] s_axil_awaddr;
    logic                   s_axil_awvalid;
    logic                   s_axil_awready;
    logic [DATA_W-1:0]      s_axil_wdata;
    logic                   s_axil_wvalid;
    logic                   s_axil_wready;
    logic [1:0]             s_axil_bresp;
    logic                   s_axil_bvalid;
    logic                   s_axil_bready;
    logic [AXIL_ADDR_W-1:0] s_axil_araddr;
    logic                   s_axil_arvalid;
    logic                   s_axil_arready;
    logic [DATA_W-1:0]      s_axil_rdata;
    logic [1:0]             s_axil_rresp;
    logic                   s_axil_rvalid;
    logic                   s_axil_rready;
    logic [DATA_W-1:0]      s_axis_tdata;
    logic [DATA_W/8-1:0]    s_axis_tstrb;
    logic                   s_axis_tlast;
    logic                   s_axis_tvalid;
    logic                   s_axis_tready;
    logic                   m_axis_tready;
    logic                   m_axis_tvalid;
    logic [DATA_W-1:0]      m_axis_tdata;
    logic                   m_axis_tlast;
    logic [DATA_W/8-1:0]    m_axis_tstrb;

    logic [31:0]       rng_state;
    int                errors;
    int                checks;
    int                timeouts;
    int                clamped;
    bit                gaps_on;
    logic [DATA_W-1:0] weights [WBANK_DEPTH];
    logic [DATA_W-1:0] acts [$];
    logic [DATA_W-1:0] expect_q [$];

    cnn_accel_top u_dut (
        .clk              (clk),
        .reset_i          (reset_i),
        .s_axil_awaddr_i  (s_axil_awaddr),
        .s_axil_awvalid_i (s_axil_awvalid),
        .s_axil_awready_o (s_axil_awready),
        .s_axil_wdata_i   (s_axil_wdata),
        .s_axil_wvalid_i  (s_axil_wvalid),
        .s_axil_wready_o  (s_axil_wready),
        .s_axil_bresp_o   (s_axil_bresp),
        .s_axil_bvalid_o  (s_axil_bvalid),
        .s_axil_bready_i  (s_axil_bready),
        .s_axil_araddr_i  (s_axil_araddr),
        .s_axil_arvalid_i (s_axil_arvalid),
        .s_axil_arready_o (s_axil_arready),
        .s_axil_rdata_o   (s_axil_rdata),
        .s_axil_rresp_o   (s_axil_rresp),
        .s_axil_rvalid_o  (s_axil_rvalid),
        .s_axil_rready_i  (s_axil_rready),
        .s_axis_tdata_i   (s_axis_tdata),
        .s_axis_tstrb_i   (s_axis_tstrb),
        .s_axis_tlast_i   (s_axis_tlast),
        .s_axis_tvalid_i  (s_axis_tvalid),
        .s_axis_tready_o  (s_axis_tready),
        .m_axis_tready_i  (m_axis_tready),
        .m_axis_tvalid_o  (m_axis_tvalid),
        .m_axis_tdata_o   (m_axis_tdata),
        .m_axis_tlast_o   (m_axis_tlast),
        .m_axis_tstrb_o   (m_axis_tstrb)
    );

    always #4 clk = ~clk;

    // upper half only since the low LCG bits repeat quickly
    function automatic logic [15:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    function automatic logic [31:0] rand_word();
        return {next_rand(), next_rand()};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t: %s", $time, what);
    endtask

    // sum of lane products over the words of output o plus bias
    function automatic int expected_out(input int o, input int iw, input int bias_v,
                                        input bit relu);
        int          sum;
        logic [31:0] a;
        logic [31:0] w;
        sum = bias_v;
        for (int k = 0; k < iw; k++) begin
            a = acts[o * iw + k];
            w = weights[k];
            for (int l = 0; l < LANES; l++) begin
                sum += int'($signed(a[ELEM_W*l +: ELEM_W])) * int'($signed(w[ELEM_W*l +: ELEM_W]));
            end
        end
        if (relu && sum < 0) begin
            sum = 0;
        end
        return sum;
    endfunction

    task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        int t;
        @(negedge clk);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        t = 0;
        while (!s_axil_awready && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!s_axil_awready) begin
            report_timeout("AXI-lite write was never accepted");
        end else begin
            check_value("WREADY with AWREADY", s_axil_wready, 1'b1);
        end
        @(negedge clk);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        t = 0;
        while (!s_axil_bvalid && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!s_axil_bvalid) begin
            report_timeout("AXI-lite write response never came");
        end else begin
            check_value("BRESP", s_axil_bresp, 2'b00);
        end
    endtask

    task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int t;
        data = '0;
        @(negedge clk);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        t = 0;
        while (!s_axil_arready && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!s_axil_arready) begin
            report_timeout("AXI-lite read address was never accepted");
        end
        @(negedge clk);
        s_axil_arvalid = 1'b0;
        t = 0;
        while (!s_axil_rvalid && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (!s_axil_rvalid) begin
            report_timeout("AXI-lite read data never came");
        end else begin
            data = s_axil_rdata;
            check_value("RRESP", s_axil_rresp, 2'b00);
        end
    endtask

    task automatic drive_inputs();
        int t;
        for (int i = 0; i < acts.size(); i++) begin
            @(negedge clk);
            if (gaps_on) begin
                s_axis_tvalid = 1'b0;
                repeat (next_rand() % 3) @(negedge clk);
            end
            s_axis_tdata  = acts[i];
            s_axis_tvalid = 1'b1;
            t = 0;
            while (!s_axis_tready && t < TIMEOUT) begin
                @(negedge clk);
                t++;
            end
            if (!s_axis_tready) begin
                report_timeout("an input beat was never accepted on S_AXIS");
                s_axis_tvalid = 1'b0;
                return;
            end
        end
        @(negedge clk);
        s_axis_tvalid = 1'b0;
    endtask

    task automatic collect_outputs(input int n);
        int got;
        int t;
        got = 0;
        t = 0;
        while (got < n && t < TIMEOUT) begin
            @(negedge clk);
            m_axis_tready = gaps_on ? (next_rand() % 4 != 0) : 1'b1;
            // handshake completes on the coming rising edge
            if (m_axis_tvalid && m_axis_tready) begin
                check_value($sformatf("output %0d data", got), m_axis_tdata, expect_q[got]);
                check_value($sformatf("output %0d last", got), m_axis_tlast, got == n - 1);
                check_value("M_AXIS TSTRB", m_axis_tstrb, 4'hF);
                got++;
                t = 0;
            end else begin
                t++;
            end
        end
        if (got < n) begin
            report_timeout("fewer results arrived on M_AXIS than expected");
        end
    endtask

    task automatic run_layer(input int iw, input int n, input int bias_v, input op_t op,
                             input bit gaps);
        logic [DATA_W-1:0] rd;
        acts.delete();
        expect_q.delete();
        for (int i = 0; i < iw * n; i++) begin
            acts.push_back(rand_word());
        end
        for (int o = 0; o < n; o++) begin
            expect_q.push_back(expected_out(o, iw, bias_v, op == OP_RELU));
            if (op == OP_RELU && expected_out(o, iw, bias_v, 1'b0) < 0) begin
                clamped++;
            end
        end
        gaps_on = gaps;
        axil_write(REG_CONFIG, (n << 8) | iw);
        axil_write(REG_BIAS, bias_v);
        axil_write(REG_CTRL, {30'd0, op, 1'b1});
        // start clears done and makes the layer busy
        axil_read(REG_STATUS, rd);
        check_value("STATUS after start", rd, 32'h2);
        fork
            drive_inputs();
            collect_outputs(n);
        join
        axil_read(REG_STATUS, rd);
        check_value("STATUS after final beat", rd, 32'h1);
        check_value("M_AXIS TVALID after layer", m_axis_tvalid, 1'b0);
    endtask

    initial begin
        logic [DATA_W-1:0] rd;
        clk            = 1'b0;
        reset_i        = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b1;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        s_axis_tdata   = '0;
        s_axis_tstrb   = '1;
        s_axis_tlast   = 1'b0;
        s_axis_tvalid  = 1'b0;
        m_axis_tready  = 1'b0;
        rng_state      = 32'd16645;
        errors         = 0;
        checks         = 0;
        timeouts       = 0;
        clamped        = 0;
        gaps_on        = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_value("S_AXIS TREADY after reset", s_axis_tready, 1'b0);
        check_value("M_AXIS TVALID after reset", m_axis_tvalid, 1'b0);
        check_value("BVALID after reset", s_axil_bvalid, 1'b0);
        check_value("RVALID after reset", s_axil_rvalid, 1'b0);

        // register readback
        for (int k = 0; k < WBANK_DEPTH; k++) begin
            weights[k] = rand_word();
            axil_write(REG_WBASE + {k[WIDX_W-1:0], 2'b00}, weights[k]);
        end
        axil_write(REG_CONFIG, 32'h0000_0603);
        axil_write(REG_BIAS, 32'hFFFF_F830);
        for (int k = 0; k < WBANK_DEPTH; k++) begin
            axil_read(REG_WBASE + {k[WIDX_W-1:0], 2'b00}, rd);
            check_value($sformatf("weight %0d readback", k), rd, weights[k]);
        end
        axil_read(REG_CONFIG, rd);
        check_value("CONFIG readback", rd, 32'h0000_0603);
        axil_read(REG_BIAS, rd);
        check_value("BIAS readback", rd, 32'hFFFF_F830);
        axil_read(REG_STATUS, rd);
        check_value("STATUS after reset", rd, 32'h0);

        run_layer(3, 6, 150, OP_LINEAR, 1'b0);
        run_layer(3, 8, -6000, OP_RELU, 1'b0);
        checks++;
        assert (clamped > 0) else begin
            errors++;
            $display("ReLU layer produced no negative sums, so clamping was never exercised");
        end
        run_layer(2, 12, -37, OP_LINEAR, 1'b1);
        run_layer(8, 5, 1000, OP_RELU, 1'b1);

        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cnn_accel_top.f
common/accel_cfg_pkg.sv
common/accel_ctrl_pkg.sv
hw/axil_regs.sv
hw/layer_ctrl.sv
datapath/mac_array.sv
hw/axis_out_fifo.sv
hw/cnn_accel_top.sv
dv/tb_cnn_accel.sv
